// File: source/acc_pkg.sv
`default_nettype none

package acc_pkg;

  // ==============================
  // sizes
  // ==============================
  localparam int n_acc = 2;
  localparam int idx_width = 1;       // bits to name an accelerator.
  localparam int addr_width = 32;
  localparam int data_width = 64;
  localparam int lane_width = 32;
  localparam int qty_width = 7;
  localparam int tag_width = 8;       // {acc index, word index}.
  localparam int conf_width = 48;
  localparam int info_width = 8;

  // response buffer inside each stream.
  localparam int resp_depth = 4;
  localparam int resp_ptr_width = 2;
  localparam int cred_width = 3;

  // conf field positions.
  localparam int conf_base_lsb = 0;
  localparam int conf_qty_lsb = 32;
  localparam int conf_idx_lsb = 40;

  // arbiter payloads, tag in the low bits.
  typedef logic [addr_width+tag_width-1:0] rd_payload_t;
  typedef logic [data_width+addr_width+tag_width-1:0] wr_payload_t;

  // one added to each lane, wrapping inside the lane.
  function automatic logic [data_width-1:0] transform(input logic [data_width-1:0] word);
    logic [data_width-1:0] result;
    for (int l = 0; l < data_width / lane_width; l++) begin
      result[l*lane_width +: lane_width] = word[l*lane_width +: lane_width] + 1'b1;
    end
    return result;
  endfunction

endpackage

`default_nettype wire

// File: source/acc_conf_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module acc_conf_ctrl (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [acc_pkg::n_acc-1:0]                        rst_accs,
  input  logic [acc_pkg::n_acc-1:0]                        start_accs,
  input  logic [1:0]                                       conf_valid,
  input  logic [acc_pkg::conf_width-1:0]                   conf,
  input  logic [acc_pkg::n_acc-1:0]                        finished,
  output logic [acc_pkg::n_acc-1:0]                        go,
  output logic [acc_pkg::n_acc-1:0][acc_pkg::addr_width-1:0] in_base,
  output logic [acc_pkg::n_acc-1:0][acc_pkg::addr_width-1:0] out_base,
  output logic [acc_pkg::n_acc-1:0][acc_pkg::qty_width-1:0]  qty,
  output logic [acc_pkg::info_width-1:0]                   info
);

  logic [acc_pkg::idx_width-1:0]  conf_sel;
  logic [acc_pkg::addr_width-1:0] conf_base;
  logic [acc_pkg::qty_width-1:0]  conf_qty;
  logic [acc_pkg::n_acc-1:0]      cfg_hit;
  logic [acc_pkg::n_acc-1:0]      start_ok;
  logic [acc_pkg::n_acc-1:0]      in_cfg;
  logic [acc_pkg::n_acc-1:0]      out_cfg;
  logic [acc_pkg::n_acc-1:0]      busy;
  logic [acc_pkg::n_acc-1:0]      done;

  assign conf_sel  = conf[acc_pkg::conf_idx_lsb +: acc_pkg::idx_width];
  assign conf_base = conf[acc_pkg::conf_base_lsb +: acc_pkg::addr_width];
  assign conf_qty  = conf[acc_pkg::conf_qty_lsb +: acc_pkg::qty_width];

  always_comb begin
    for (int i = 0; i < acc_pkg::n_acc; i++) begin
      // queues are frozen while the accelerator runs.
      cfg_hit[i]  = (conf_sel == acc_pkg::idx_width'(i)) && !busy[i];
      start_ok[i] = start_accs[i] && in_cfg[i] && out_cfg[i] && !busy[i];
    end
  end

  // ==============================
  // per accelerator state
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      in_cfg  <= '0;
      out_cfg <= '0;
      busy    <= '0;
      done    <= '0;
      go      <= '0;
    end else begin
      for (int i = 0; i < acc_pkg::n_acc; i++) begin
        if (rst_accs[i]) begin
          in_cfg[i]  <= 1'b0;
          out_cfg[i] <= 1'b0;
          busy[i]    <= 1'b0;
          done[i]    <= 1'b0;
          go[i]      <= 1'b0;
        end else begin
          go[i] <= 1'b0;
          if (conf_valid[0] && cfg_hit[i]) in_cfg[i] <= 1'b1;
          if (conf_valid[1] && cfg_hit[i]) out_cfg[i] <= 1'b1;
          if (start_ok[i]) begin
            go[i]   <= 1'b1;
            busy[i] <= 1'b1;
            done[i] <= 1'b0;  // cleared by the new run.
          end else if (finished[i]) begin
            busy[i] <= 1'b0;
            done[i] <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < acc_pkg::n_acc; i++) begin
      if (conf_valid[0] && cfg_hit[i]) begin
        in_base[i] <= conf_base;
        qty[i]     <= conf_qty;   // input queue sets the length.
      end
      if (conf_valid[1] && cfg_hit[i]) out_base[i] <= conf_base;
    end
  end

  // status word.
  assign info = {{(acc_pkg::info_width - 2 * acc_pkg::n_acc){1'b0}}, done, busy};

endmodule

`default_nettype wire

// File: source/acc_stream.sv
`timescale 1ns/1ps
`default_nettype none

module acc_stream (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [acc_pkg::idx_width-1:0]  acc_idx,
  input  logic                           go,
  input  logic [acc_pkg::addr_width-1:0] in_base,
  input  logic [acc_pkg::addr_width-1:0] out_base,
  input  logic [acc_pkg::qty_width-1:0]  qty,
  output logic                           rd_req,
  output logic [acc_pkg::addr_width-1:0] rd_addr,
  output logic [acc_pkg::tag_width-1:0]  rd_tag,
  input  logic                           rd_grant,
  input  logic                           resp_rd_valid,
  input  logic [acc_pkg::data_width-1:0] resp_rd_data,
  input  logic [acc_pkg::tag_width-1:0]  resp_rd_mdata,
  output logic                           wr_req,
  output logic [acc_pkg::addr_width-1:0] wr_addr,
  output logic [acc_pkg::data_width-1:0] wr_data,
  output logic [acc_pkg::tag_width-1:0]  wr_tag,
  input  logic                           wr_grant,
  input  logic                           resp_wr_valid,
  input  logic [acc_pkg::tag_width-1:0]  resp_wr_mdata,
  output logic                           finished
);

  localparam int tag_top = acc_pkg::tag_width - 1;

  logic                              running;
  logic [acc_pkg::qty_width-1:0]     rd_cnt;
  logic [acc_pkg::qty_width-1:0]     ack_cnt;
  logic [acc_pkg::cred_width-1:0]    credits;   // free response slots not yet promised.
  logic [acc_pkg::resp_ptr_width:0]  head;
  logic [acc_pkg::resp_ptr_width:0]  tail;
  logic [acc_pkg::data_width-1:0]    resp_data_q [acc_pkg::resp_depth];
  logic [acc_pkg::qty_width-1:0]     resp_idx_q [acc_pkg::resp_depth];
  logic [acc_pkg::qty_width-1:0]     head_idx;
  logic                              rd_hit;
  logic                              wr_hit;
  logic                              rd_fire;
  logic                              wr_fire;

  // keep only traffic tagged with our index.
  assign rd_hit = running && resp_rd_valid && (resp_rd_mdata[tag_top -: acc_pkg::idx_width] == acc_idx);
  assign wr_hit = running && resp_wr_valid && (resp_wr_mdata[tag_top -: acc_pkg::idx_width] == acc_idx);

  // ==============================
  // read side
  // ==============================
  assign rd_req  = running && (rd_cnt != qty) && (credits != '0);
  assign rd_addr = in_base + acc_pkg::addr_width'(rd_cnt);
  assign rd_tag  = {acc_idx, rd_cnt};
  assign rd_fire = rd_req && rd_grant;

  // ==============================
  // write side
  // ==============================
  assign head_idx = resp_idx_q[head[acc_pkg::resp_ptr_width-1:0]];
  assign wr_req   = (head != tail);
  assign wr_addr  = out_base + acc_pkg::addr_width'(head_idx);
  assign wr_data  = resp_data_q[head[acc_pkg::resp_ptr_width-1:0]];
  assign wr_tag   = {acc_idx, head_idx};
  assign wr_fire  = wr_req && wr_grant;

  always_ff @(posedge clk) begin
    if (rst) begin
      running  <= 1'b0;
      rd_cnt   <= '0;
      ack_cnt  <= '0;
      credits  <= acc_pkg::cred_width'(acc_pkg::resp_depth);
      head     <= '0;
      tail     <= '0;
      finished <= 1'b0;
    end else begin
      finished <= 1'b0;
      if (go) begin
        rd_cnt   <= '0;
        ack_cnt  <= '0;
        running  <= (qty != '0);
        finished <= (qty == '0);  // empty queue ends at once.
      end else begin
        if (rd_fire) rd_cnt <= rd_cnt + 1'b1;
        if (rd_hit) tail <= tail + 1'b1;
        if (wr_fire) head <= head + 1'b1;
        case ({rd_fire, wr_fire})
          2'b10:   credits <= credits - 1'b1;
          2'b01:   credits <= credits + 1'b1;
          default: credits <= credits;
        endcase
        if (wr_hit) begin
          ack_cnt <= ack_cnt + 1'b1;
          if (ack_cnt == qty - 1'b1) begin
            running  <= 1'b0;
            finished <= 1'b1;
          end
        end
      end
    end
  end

  // responses are stored already transformed.
  always_ff @(posedge clk) begin
    if (rd_hit) begin
      resp_data_q[tail[acc_pkg::resp_ptr_width-1:0]] <= acc_pkg::transform(resp_rd_data);
      resp_idx_q[tail[acc_pkg::resp_ptr_width-1:0]]  <= resp_rd_mdata[acc_pkg::qty_width-1:0];
    end
  end

endmodule

`default_nettype wire

// File: source/req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module req_arbiter #(
  parameter type payload_t = acc_pkg::rd_payload_t
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [acc_pkg::n_acc-1:0]           req,
  input  payload_t [acc_pkg::n_acc-1:0]       payload,
  input  logic                                available,
  output logic [acc_pkg::n_acc-1:0]           grant,
  output logic                                out_en,
  output payload_t                            out_payload
);

  logic [acc_pkg::idx_width-1:0] last;   // last winner.
  logic [acc_pkg::idx_width-1:0] win;
  logic [acc_pkg::idx_width-1:0] cand;
  logic                          found;

  // ==============================
  // round-robin choice
  // ==============================
  always_comb begin
    grant = '0;
    win   = last;
    found = 1'b0;
    cand  = last;
    // start one past the last winner.
    for (int k = 1; k <= acc_pkg::n_acc; k++) begin
      cand = acc_pkg::idx_width'((int'(last) + k) % acc_pkg::n_acc);
      if (!found && req[cand]) begin
        found = 1'b1;
        win   = cand;
      end
    end
    if (available && found) grant[win] = 1'b1;
  end

  // ==============================
  // port register
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      out_en <= 1'b0;
      last   <= '0;
    end else begin
      out_en <= |grant;
      if (|grant) last <= win;
    end
  end

  always_ff @(posedge clk) begin
    if (|grant) out_payload <= payload[win];  // held until the next grant.
  end

endmodule

`default_nettype wire

// File: source/acc_management.sv
`timescale 1ns/1ps
`default_nettype none

module acc_management (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [acc_pkg::n_acc-1:0]       rst_accs,
  input  logic [acc_pkg::n_acc-1:0]       start_accs,
  input  logic [1:0]                      conf_valid,
  input  logic [acc_pkg::conf_width-1:0]  conf,
  output logic                            req_rd_en,
  output logic [acc_pkg::addr_width-1:0]  req_rd_addr,
  output logic [acc_pkg::tag_width-1:0]   req_rd_mdata,
  input  logic                            req_rd_available,
  input  logic                            resp_rd_valid,
  input  logic [acc_pkg::data_width-1:0]  resp_rd_data,
  input  logic [acc_pkg::tag_width-1:0]   resp_rd_mdata,
  output logic                            req_wr_en,
  output logic [acc_pkg::addr_width-1:0]  req_wr_addr,
  output logic [acc_pkg::tag_width-1:0]   req_wr_mdata,
  output logic [acc_pkg::data_width-1:0]  req_wr_data,
  input  logic                            req_wr_available,
  input  logic                            resp_wr_valid,
  input  logic [acc_pkg::tag_width-1:0]   resp_wr_mdata,
  output logic [acc_pkg::info_width-1:0]  info
);

  logic [acc_pkg::n_acc-1:0]                         go;
  logic [acc_pkg::n_acc-1:0]                         finished;
  logic [acc_pkg::n_acc-1:0][acc_pkg::addr_width-1:0] in_base;
  logic [acc_pkg::n_acc-1:0][acc_pkg::addr_width-1:0] out_base;
  logic [acc_pkg::n_acc-1:0][acc_pkg::qty_width-1:0]  qty;
  logic [acc_pkg::n_acc-1:0]                         rd_req;
  logic [acc_pkg::n_acc-1:0]                         rd_grant;
  logic [acc_pkg::n_acc-1:0][acc_pkg::addr_width-1:0] rd_addr;
  logic [acc_pkg::n_acc-1:0][acc_pkg::tag_width-1:0]  rd_tag;
  logic [acc_pkg::n_acc-1:0]                         wr_req;
  logic [acc_pkg::n_acc-1:0]                         wr_grant;
  logic [acc_pkg::n_acc-1:0][acc_pkg::addr_width-1:0] wr_addr;
  logic [acc_pkg::n_acc-1:0][acc_pkg::data_width-1:0] wr_data;
  logic [acc_pkg::n_acc-1:0][acc_pkg::tag_width-1:0]  wr_tag;
  acc_pkg::rd_payload_t [acc_pkg::n_acc-1:0]          rd_payload;
  acc_pkg::wr_payload_t [acc_pkg::n_acc-1:0]          wr_payload;
  acc_pkg::rd_payload_t                              rd_out;
  acc_pkg::wr_payload_t                              wr_out;

  acc_conf_ctrl u_acc_conf_ctrl (
    .clk        (clk),
    .rst        (rst),
    .rst_accs   (rst_accs),
    .start_accs (start_accs),
    .conf_valid (conf_valid),
    .conf       (conf),
    .finished   (finished),
    .go         (go),
    .in_base    (in_base),
    .out_base   (out_base),
    .qty        (qty),
    .info       (info)
  );

  // ==============================
  // accelerators
  // ==============================
  for (genvar i = 0; i < acc_pkg::n_acc; i++) begin : g_acc
    acc_stream u_acc_stream (
      .clk           (clk),
      .rst           (rst | rst_accs[i]),  // soft reset per accelerator.
      .acc_idx       (acc_pkg::idx_width'(i)),
      .go            (go[i]),
      .in_base       (in_base[i]),
      .out_base      (out_base[i]),
      .qty           (qty[i]),
      .rd_req        (rd_req[i]),
      .rd_addr       (rd_addr[i]),
      .rd_tag        (rd_tag[i]),
      .rd_grant      (rd_grant[i]),
      .resp_rd_valid (resp_rd_valid),
      .resp_rd_data  (resp_rd_data),
      .resp_rd_mdata (resp_rd_mdata),
      .wr_req        (wr_req[i]),
      .wr_addr       (wr_addr[i]),
      .wr_data       (wr_data[i]),
      .wr_tag        (wr_tag[i]),
      .wr_grant      (wr_grant[i]),
      .resp_wr_valid (resp_wr_valid),
      .resp_wr_mdata (resp_wr_mdata),
      .finished      (finished[i])
    );
    assign rd_payload[i] = {rd_addr[i], rd_tag[i]};
    assign wr_payload[i] = {wr_data[i], wr_addr[i], wr_tag[i]};
  end

  // ==============================
  // memory ports
  // ==============================
  req_arbiter #(.payload_t(acc_pkg::rd_payload_t)) u_rd_arb (
    .clk         (clk),
    .rst         (rst),
    .req         (rd_req),
    .payload     (rd_payload),
    .available   (req_rd_available),
    .grant       (rd_grant),
    .out_en      (req_rd_en),
    .out_payload (rd_out)
  );

  req_arbiter #(.payload_t(acc_pkg::wr_payload_t)) u_wr_arb (
    .clk         (clk),
    .rst         (rst),
    .req         (wr_req),
    .payload     (wr_payload),
    .available   (req_wr_available),
    .grant       (wr_grant),
    .out_en      (req_wr_en),
    .out_payload (wr_out)
  );

  assign req_rd_mdata = rd_out[acc_pkg::tag_width-1:0];
  assign req_rd_addr  = rd_out[acc_pkg::tag_width +: acc_pkg::addr_width];
  assign req_wr_mdata = wr_out[acc_pkg::tag_width-1:0];
  assign req_wr_addr  = wr_out[acc_pkg::tag_width +: acc_pkg::addr_width];
  assign req_wr_data  = wr_out[acc_pkg::tag_width + acc_pkg::addr_width +: acc_pkg::data_width];

endmodule

`default_nettype wire

// File: dv/acc_management_chk.sv
`timescale 1ns/1ps
`default_nettype none

module acc_management_chk (
  input logic                      clk,
  input logic                      rst,
  input logic [acc_pkg::n_acc-1:0] grant,
  input logic                      available,
  input logic                      out_en
);

  // ==============================
  // arbiter rules
  // ==============================
  grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("arbiter gave more than one grant in a cycle");

  port_after_available: assert property (@(posedge clk) disable iff (rst)
    out_en |-> $past(available))
    else $error("memory request issued after a cycle with available low");

endmodule

bind req_arbiter acc_management_chk u_arb_chk (
  .clk       (clk),
  .rst       (rst),
  .grant     (grant),
  .available (available),
  .out_en    (out_en)
);

`default_nettype wire

// File: dv/acc_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module acc_monitor (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [acc_pkg::n_acc-1:0]      rst_accs,
  input  logic [acc_pkg::n_acc-1:0]      start_accs,
  input  logic [1:0]                     conf_valid,
  input  logic [acc_pkg::conf_width-1:0] conf,
  input  logic                           req_rd_en,
  input  logic                           req_wr_en,
  input  acc_pkg::wr_payload_t           wr_port,
  input  logic                           resp_wr_valid,
  input  logic [acc_pkg::tag_width-1:0]  resp_wr_mdata,
  input  logic [acc_pkg::info_width-1:0] info,
  output int                             errors
);

  localparam logic [acc_pkg::data_width-1:0] fill_xor = 64'h5a5a_c3c3_0f0f_9696;
  localparam int idx_top = acc_pkg::tag_width - 1;

  logic [acc_pkg::n_acc-1:0]      in_cfg;
  logic [acc_pkg::n_acc-1:0]      out_cfg;
  logic [acc_pkg::n_acc-1:0]      busy_m;
  logic [acc_pkg::n_acc-1:0]      done_m;
  logic [acc_pkg::n_acc-1:0]      go_m;      // go high this cycle.
  logic [acc_pkg::n_acc-1:0]      fin_m;     // finished high this cycle.
  logic [acc_pkg::n_acc-1:0]      run_m;
  logic [acc_pkg::n_acc-1:0]      run_last;
  logic [acc_pkg::addr_width-1:0] in_m [acc_pkg::n_acc];
  logic [acc_pkg::addr_width-1:0] out_m [acc_pkg::n_acc];
  logic [acc_pkg::qty_width-1:0]  qty_m [acc_pkg::n_acc];
  logic [127:0]                   seen [acc_pkg::n_acc];
  int                             seen_cnt [acc_pkg::n_acc];
  int                             acks [acc_pkg::n_acc];

  // memory word at addr, plus one in each 32-bit lane.
  function automatic logic [acc_pkg::data_width-1:0] expected_word(input logic [31:0] addr);
    logic [63:0] src;
    logic [31:0] lo;
    logic [31:0] hi;
    src = {addr, addr} ^ fill_xor;
    lo  = src[31:0] + 32'd1;
    hi  = src[63:32] + 32'd1;
    return {hi, lo};
  endfunction

  always @(posedge clk) begin : compare
    logic [acc_pkg::info_width-1:0] exp_info;
    logic [acc_pkg::idx_width-1:0]  w_acc;
    logic [acc_pkg::qty_width-1:0]  w_idx;
    logic [acc_pkg::addr_width-1:0] w_addr;
    logic [acc_pkg::data_width-1:0] w_data;
    logic                           hit;
    logic                           ok;
    logic                           ack;
    logic                           fin_next;
    if (rst) begin
      errors   = 0;
      in_cfg   = '0;
      out_cfg  = '0;
      busy_m   = '0;
      done_m   = '0;
      go_m     = '0;
      fin_m    = '0;
      run_m    = '0;
      run_last = '0;
    end else begin
      // ==============================
      // status word and port traffic
      // ==============================
      exp_info = {{(acc_pkg::info_width - 2 * acc_pkg::n_acc){1'b0}}, done_m, busy_m};
      if (info !== exp_info) begin
        errors++;
        $display("FAIL %0t info seen %h expected %h", $time, info, exp_info);
      end
      if ((req_rd_en || req_wr_en) && run_last == '0) begin
        errors++;
        $display("%0t: memory request while no accelerator was running", $time);
      end
      if (req_wr_en) begin
        w_acc  = wr_port[idx_top -: acc_pkg::idx_width];
        w_idx  = wr_port[acc_pkg::qty_width-1:0];
        w_addr = wr_port[acc_pkg::tag_width +: acc_pkg::addr_width];
        w_data = wr_port[acc_pkg::tag_width + acc_pkg::addr_width +: acc_pkg::data_width];
        if (w_idx >= qty_m[w_acc]) begin
          errors++;
          $display("%0t: accelerator %0d wrote word %0d past its queue", $time, w_acc, w_idx);
        end else begin
          if (w_addr !== out_m[w_acc] + 32'(w_idx)) begin
            errors++;
            $display("FAIL %0t req_wr_addr seen %h expected %h", $time, w_addr,
                     out_m[w_acc] + 32'(w_idx));
          end
          if (w_data !== expected_word(in_m[w_acc] + 32'(w_idx))) begin
            errors++;
            $display("FAIL %0t req_wr_data seen %h expected %h", $time, w_data,
                     expected_word(in_m[w_acc] + 32'(w_idx)));
          end
          if (seen[w_acc][w_idx]) begin
            errors++;
            $display("%0t: accelerator %0d wrote word %0d twice", $time, w_acc, w_idx);
          end else begin
            seen[w_acc][w_idx] = 1'b1;
            seen_cnt[w_acc]++;
          end
        end
      end
      run_last = run_m;

      // ==============================
      // expected state for next cycle
      // ==============================
      for (int i = 0; i < acc_pkg::n_acc; i++) begin
        hit = conf[acc_pkg::conf_idx_lsb +: acc_pkg::idx_width] == acc_pkg::idx_width'(i);
        hit = hit && !busy_m[i];
        ok  = start_accs[i] && in_cfg[i] && out_cfg[i] && !busy_m[i];
        ack = resp_wr_valid && run_m[i]
              && resp_wr_mdata[idx_top -: acc_pkg::idx_width] == acc_pkg::idx_width'(i);
        fin_next = 1'b0;
        if (rst_accs[i]) begin
          in_cfg[i]  = 1'b0;
          out_cfg[i] = 1'b0;
          busy_m[i]  = 1'b0;
          done_m[i]  = 1'b0;
          run_m[i]   = 1'b0;
          ok         = 1'b0;
        end else begin
          if (go_m[i]) begin
            run_m[i] = qty_m[i] != '0;
            fin_next = qty_m[i] == '0;  // empty queue.
            acks[i]  = 0;
          end else if (ack) begin
            acks[i]++;
            if (acks[i] == int'(qty_m[i])) begin
              run_m[i] = 1'b0;
              fin_next = 1'b1;
            end
          end
          if (conf_valid[0] && hit) begin
            in_cfg[i] = 1'b1;
            in_m[i]   = conf[acc_pkg::conf_base_lsb +: acc_pkg::addr_width];
            qty_m[i]  = conf[acc_pkg::conf_qty_lsb +: acc_pkg::qty_width];
          end
          if (conf_valid[1] && hit) begin
            out_cfg[i] = 1'b1;
            out_m[i]   = conf[acc_pkg::conf_base_lsb +: acc_pkg::addr_width];
          end
          if (ok) begin
            busy_m[i]   = 1'b1;
            done_m[i]   = 1'b0;
            seen[i]     = '0;
            seen_cnt[i] = 0;
          end else if (fin_m[i]) begin
            busy_m[i] = 1'b0;
            done_m[i] = 1'b1;
            if (seen_cnt[i] != int'(qty_m[i])) begin
              errors++;
              $display("%0t: accelerator %0d finished after %0d of %0d writes", $time, i,
                       seen_cnt[i], qty_m[i]);
            end
          end
        end
        go_m[i]  = ok;
        fin_m[i] = fin_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/acc_management_tb.sv
`timescale 1ns/1ps
`default_nettype none

module acc_management_tb;

  localparam int clk_period = 100;
  localparam logic [acc_pkg::data_width-1:0] fill_xor = 64'h5a5a_c3c3_0f0f_9696;
  localparam int total_words = 16 + 24 + 20 + 0 + 30 + 30 + 40;  // all queues run.
  // 8 cycles per word worst case, rounded up, then doubled for setup.
  localparam int watchdog_cycles = ((total_words * 8 + 9999) / 10000) * 20000;

  logic                           clk = 1'b0;
  logic                           rst;
  logic [acc_pkg::n_acc-1:0]      rst_accs;
  logic [acc_pkg::n_acc-1:0]      start_accs;
  logic [1:0]                     conf_valid;
  logic [acc_pkg::conf_width-1:0] conf;
  logic                           req_rd_en;
  logic [acc_pkg::addr_width-1:0] req_rd_addr;
  logic [acc_pkg::tag_width-1:0]  req_rd_mdata;
  logic                           req_rd_available = 1'b1;
  logic                           resp_rd_valid = 1'b0;
  logic [acc_pkg::data_width-1:0] resp_rd_data = '0;
  logic [acc_pkg::tag_width-1:0]  resp_rd_mdata = '0;
  logic                           req_wr_en;
  logic [acc_pkg::addr_width-1:0] req_wr_addr;
  logic [acc_pkg::tag_width-1:0]  req_wr_mdata;
  logic [acc_pkg::data_width-1:0] req_wr_data;
  logic                           req_wr_available = 1'b1;
  logic                           resp_wr_valid = 1'b0;
  logic [acc_pkg::tag_width-1:0]  resp_wr_mdata = '0;
  logic [acc_pkg::info_width-1:0] info;
  int                             errors;
  logic                           gaps = 1'b0;    // random availability gaps.
  logic                           timed_out = 1'b0;
  logic                           ended = 1'b0;
  logic [31:0]                    lfsr = 32'hbb3a;
  int                             cycle = 0;
  logic [acc_pkg::addr_width-1:0] rd_addr_q [$];
  logic [acc_pkg::tag_width-1:0]  rd_tag_q [$];
  int                             rd_due_q [$];
  logic [acc_pkg::tag_width-1:0]  ack_tag_q [$];
  int                             ack_due_q [$];

  always #(clk_period / 2) clk = ~clk;

  acc_management u_acc_management (
    .clk (clk), .rst (rst), .rst_accs (rst_accs), .start_accs (start_accs),
    .conf_valid (conf_valid), .conf (conf),
    .req_rd_en (req_rd_en), .req_rd_addr (req_rd_addr), .req_rd_mdata (req_rd_mdata),
    .req_rd_available (req_rd_available), .resp_rd_valid (resp_rd_valid),
    .resp_rd_data (resp_rd_data), .resp_rd_mdata (resp_rd_mdata),
    .req_wr_en (req_wr_en), .req_wr_addr (req_wr_addr), .req_wr_mdata (req_wr_mdata),
    .req_wr_data (req_wr_data), .req_wr_available (req_wr_available),
    .resp_wr_valid (resp_wr_valid), .resp_wr_mdata (resp_wr_mdata), .info (info)
  );

  acc_monitor u_acc_monitor (
    .clk (clk), .rst (rst), .rst_accs (rst_accs), .start_accs (start_accs),
    .conf_valid (conf_valid), .conf (conf), .req_rd_en (req_rd_en), .req_wr_en (req_wr_en),
    .wr_port ({req_wr_data, req_wr_addr, req_wr_mdata}), .resp_wr_valid (resp_wr_valid),
    .resp_wr_mdata (resp_wr_mdata), .info (info), .errors (errors)
  );

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [3:0] bits);
    bits = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[2:0], lfsr[0]};
    end
  endtask

  // ==============================
  // memory model
  // ==============================
  always @(posedge clk) begin : memory_model
    int hit;
    logic [3:0] r;
    cycle++;
    if (req_rd_en === 1'b1) begin
      take_bits(2, r);
      rd_addr_q.push_back(req_rd_addr);
      rd_tag_q.push_back(req_rd_mdata);
      rd_due_q.push_back(cycle + 1 + int'(r[1:0]));  // 1 to 4 cycles.
    end
    if (req_wr_en === 1'b1) begin
      ack_tag_q.push_back(req_wr_mdata);
      ack_due_q.push_back(cycle + 2);
    end
    #1;
    hit = -1;
    for (int j = 0; j < rd_due_q.size(); j++) begin
      if (hit < 0 && rd_due_q[j] <= cycle) hit = j;
    end
    resp_rd_valid = hit >= 0;
    if (hit >= 0) begin
      resp_rd_data  = {rd_addr_q[hit], rd_addr_q[hit]} ^ fill_xor;
      resp_rd_mdata = rd_tag_q[hit];
      rd_addr_q.delete(hit);
      rd_tag_q.delete(hit);
      rd_due_q.delete(hit);
    end
    resp_wr_valid = ack_due_q.size() > 0 && ack_due_q[0] <= cycle;
    if (resp_wr_valid) begin
      resp_wr_mdata = ack_tag_q.pop_front();
      void'(ack_due_q.pop_front());
    end
    take_bits(2, r);
    req_rd_available = !(gaps && r[1:0] == 2'b11);
    take_bits(2, r);
    req_wr_available = !(gaps && r[1:0] == 2'b11);
  end

  // ==============================
  // stimulus
  // ==============================
  task automatic cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  function automatic logic [acc_pkg::conf_width-1:0] make_conf(input int idx,
      input logic [31:0] base, input logic [6:0] len);
    logic [acc_pkg::conf_width-1:0] c;
    c = '0;
    c[acc_pkg::conf_base_lsb +: acc_pkg::addr_width] = base;
    c[acc_pkg::conf_qty_lsb +: acc_pkg::qty_width]   = len;
    c[acc_pkg::conf_idx_lsb] = idx[0];
    return c;
  endfunction

  // which is 0 for the input queue, 1 for the output queue.
  task automatic load_queue(input int idx, input int which, input logic [31:0] base,
      input logic [6:0] len);
    conf = make_conf(idx, base, len);
    conf_valid = (which == 0) ? 2'b01 : 2'b10;
    cycles(1);
    conf_valid = 2'b00;
  endtask

  task automatic configure(input int idx, input logic [31:0] in_b, input logic [31:0] out_b,
      input logic [6:0] len);
    load_queue(idx, 0, in_b, len);
    load_queue(idx, 1, out_b, 7'd0);
  endtask

  task automatic start(input logic [1:0] mask);
    start_accs = mask;
    cycles(1);
    start_accs = '0;
  endtask

  task automatic soft_reset(input logic [1:0] mask);
    rst_accs = mask;
    cycles(1);
    rst_accs = '0;
  endtask

  task automatic wait_done(input logic [1:0] mask);
    while ((info[3:2] & mask) != mask) cycles(1);
  endtask

  task automatic run_tests();
    cycles(10);                                    // idle, nothing moves.
    configure(0, 32'h1000, 32'h8000, 7'd16);
    start(2'b01);
    wait_done(2'b01);
    gaps = 1'b1;
    configure(0, 32'h2000, 32'h9000, 7'd24);
    configure(1, 32'h3000, 32'ha000, 7'd20);
    start(2'b11);
    wait_done(2'b11);
    soft_reset(2'b10);
    load_queue(1, 0, 32'h3800, 7'd8);              // output queue left out.
    start(2'b10);
    cycles(20);
    configure(0, 32'h4000, 32'hb000, 7'd0);
    start(2'b01);
    wait_done(2'b01);
    configure(0, 32'h5000, 32'hc000, 7'd30);
    configure(1, 32'h6000, 32'hd000, 7'd40);
    start(2'b11);
    cycles(20);
    soft_reset(2'b01);
    cycles(20);
    configure(0, 32'h7000, 32'he000, 7'd30);
    start(2'b01);
    wait_done(2'b11);
    cycles(10);
  endtask

  initial begin
    rst        = 1'b1;
    rst_accs   = '0;
    start_accs = '0;
    conf_valid = '0;
    conf       = '0;
    cycles(2);
    rst = 1'b0;
    fork
      run_tests();
      begin
        repeat (watchdog_cycles) @(posedge clk);
        timed_out = 1'b1;
      end
    join_any
    ended = 1'b1;
    if (timed_out) $display("watchdog expired after %0d cycles", watchdog_cycles);
    $display("acc_management_tb: %0d errors", errors);
    if (!timed_out && errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // run stopped early by a failing assertion.
  final begin
    if (!ended) $display("RESULT: FAIL");
  end

endmodule

`default_nettype wire

// File: flist.f
source/acc_pkg.sv
source/acc_conf_ctrl.sv
source/acc_stream.sv
source/req_arbiter.sv
source/acc_management.sv
dv/acc_management_chk.sv
dv/acc_monitor.sv
dv/acc_management_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module acc_management_tb \
		-Mdir obj_dir -f flist.f
	out="$$(./obj_dir/Vacc_management_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
